//--- cuDecode.f
rtl/cuPkg.sv
rtl/decodeClassStage.sv
rtl/execCtrlStage.sv
rtl/memBranchCtrlStage.sv
rtl/instrDecoder.sv
testbench/instrDecoder_asserts.sv
testbench/tbInstrDecoder.sv

//--- rtl/cuPkg.sv
/* shared definitions for the cuDecode instruction decoder
   opcodes, alu codes, instruction field views and the stage payloads
   imported by each pipeline stage and by the testbench */
package cuPkg;

	localparam int INSTR_W  = 16; // one instruction word
	localparam int OPCODE_W = 4;  // top nibble selects the class
	localparam int ALUOP_W  = 4;  // alu operation select

	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP      = 4'd0,
		OP_ARITH    = 4'd1,  // div mul add sub
		OP_SHIFT    = 4'd2,  // shl shr inc dec
		OP_LOGIC    = 4'd3,  // or and not mov
		OP_BRANCH   = 4'd4,  // jump through Rdst
		OP_FLAG     = 4'd5,  // set or clear one flag
		OP_STACK    = 4'd6,  // push pop
		OP_MEM      = 4'd7,  // ldd std, in/out dropped
		OP_IMM      = 4'd8,  // ldm, call and jumps on immediate
		OP_CLRFLAGS = 4'd9,
		OP_CALLREG  = 4'd10
	} opcode_e; // 11 to 15 unused, they decode as nop

	typedef enum logic [ALUOP_W-1:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		INC = 4'd2,
		DEC = 4'd3,
		AND = 4'd4,
		OR  = 4'd5,
		NOT = 4'd6,
		SHL = 4'd7,
		SHR = 4'd8,
		MUL = 4'd9,  // result spans low and high register
		DIV = 4'd10,
		MOV = 4'd11  // also the idle operation
	} aluOp_e;

	typedef enum logic [1:0] {
		SRC_REG  = 2'd0, // Rsrc from register file
		SRC_DATA = 2'd1, // data word following ldm
		SRC_SHMT = 2'd2  // shift amount field
	} aluSrc_e;

	typedef enum logic [1:0] {
		JMP_ALWAYS = 2'd0,
		JMP_C      = 2'd1,
		JMP_N      = 2'd2,
		JMP_Z      = 2'd3
	} jmpType_e;

	typedef enum logic [1:0] {
		SP_HOLD = 2'd0,
		SP_POP  = 2'd1,
		SP_PUSH = 2'd2
	} spOp_e;

	// the four ways one instruction word is read
	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] rdst1;
		logic [2:0] rsrc;
		logic [3:0] shmt;
		logic [1:0] funct;
	} rFmt_t;

	typedef struct packed {
		opcode_e    opcode;
		logic       op;    // 1 sets, 0 clears
		logic [8:0] rsvd;
		logic [1:0] funct; // flag select z n c ovf
	} cFmt_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] rdst1;
		logic       pc;    // push/pop the pc
		logic       flags; // push/pop the flags
		logic [4:0] rsvd;
		logic [1:0] funct; // 0 push, 1 pop
	} sFmt_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] rdst1;
		logic [1:0] rsvd;
		logic [3:0] imm;    // upper address nibble
		logic [2:0] iFunct; // full 3 bits, jz/jn imm need them
	} iFmt_t;

	typedef union packed {
		rFmt_t rView;
		cFmt_t cView;
		sFmt_t sView;
		iFmt_t iView;
	} instrFmt_u;

	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic ovf;
	} flagMask_t;

	typedef struct packed {
		opcode_e   cls;
		instrFmt_u fmt;
		logic      isKnown; // low means decode to all inactive
	} classInstr_t;

	typedef struct packed {
		aluOp_e  aluOp;
		aluSrc_e aluSrc;
		logic    regLowWrite;
		logic    regHighWrite;
	} execCtrl_t;

	typedef struct packed {
		execCtrl_t   ctrl;
		flagMask_t   setMask;
		flagMask_t   clrMask;
		classInstr_t src; // carried on for stage 3
	} execPayload_t;

	typedef struct packed {
		execCtrl_t exec;
		flagMask_t setMask;
		flagMask_t clrMask;
		logic      memRead;
		logic      memWrite;
		logic      memToReg;
		spOp_e     spOp;
		logic      pcPushPop;
		logic      flagsPushPop;
		logic      memDataSrc;   // pc/flags instead of Rdst
		logic      memAddrSrc;   // sp instead of Rdst
		logic      isJump;
		jmpType_e  jmpType;
		logic      jmpSrc;       // immediate target
	} ctrlWord_t;

endpackage

//--- rtl/decodeClassStage.sv
/* decoder stage 1, takes one instruction per transfer
   and registers it with its opcode class and a known flag */
`timescale 1ns/1ps

module decodeClassStage (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       inValid,
	output logic                       inReady,
	input  logic [cuPkg::INSTR_W-1:0]  instr,
	output logic                       classValid,
	input  logic                       classReady,
	output cuPkg::classInstr_t         classOut
);
	import cuPkg::*;

	instrFmt_u   fmt;     // incoming word seen through the views
	classInstr_t nxt;     // entry to be loaded
	logic        known;
	logic        accept;

	assign fmt = instrFmt_u'(instr);

	// opcode 0, unused opcodes and the dropped port i/o go inactive
	always_comb begin
		known = 1'b1;
		case (fmt.rView.opcode)
			OP_ARITH, OP_SHIFT, OP_LOGIC, OP_BRANCH, OP_FLAG,
			OP_STACK, OP_IMM, OP_CLRFLAGS, OP_CALLREG: known = 1'b1;
			OP_MEM: known = fmt.rView.funct[1]; // funct 0 out, 1 in
			default: known = 1'b0; // nop and 11..15
		endcase
	end

	always_comb begin
		nxt.cls     = fmt.rView.opcode;
		nxt.fmt     = fmt;
		nxt.isKnown = known;
	end

	// one entry, ready when empty or draining this cycle
	assign inReady = ~classValid | classReady;
	assign accept  = inValid & inReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			classValid <= 1'b0;
		end else if (inReady) begin
			classValid <= inValid; // refill or go empty
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			classOut <= nxt; // payload held while stalled
		end
	end

endmodule

//--- rtl/execCtrlStage.sv
/* decoder stage 2, turns a classified instruction into alu,
   register write and flag mask controls, passing the entry on */
`timescale 1ns/1ps

module execCtrlStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 classValid,
	output logic                 classReady,
	input  cuPkg::classInstr_t   classIn,
	output logic                 execValid,
	input  logic                 execReady,
	output cuPkg::execPayload_t  execOut
);
	import cuPkg::*;

	instrFmt_u    fmt;
	flagMask_t    sel;   // flag picked by the c-type funct
	execPayload_t nxt;

	assign fmt = classIn.fmt;

	always_comb begin
		sel = '0;
		case (fmt.cView.funct)
			2'd0: sel.z = 1'b1;
			2'd1: sel.n = 1'b1;
			2'd2: sel.c = 1'b1;
			default: sel.ovf = 1'b1;
		endcase
	end

	always_comb begin
		nxt             = '0;
		nxt.ctrl.aluOp  = MOV;     // idle op for anything non-alu
		nxt.ctrl.aluSrc = SRC_REG;
		nxt.src         = classIn;
		if (classIn.isKnown) begin
			case (classIn.cls)
				OP_ARITH: begin
					case (fmt.rView.funct)
						2'd0: nxt.ctrl.aluOp = DIV;
						2'd1: nxt.ctrl.aluOp = MUL;
						2'd2: nxt.ctrl.aluOp = ADD;
						default: nxt.ctrl.aluOp = SUB;
					endcase
					nxt.ctrl.regLowWrite  = 1'b1;
					nxt.ctrl.regHighWrite = (fmt.rView.funct == 2'd1); // mul high half
				end
				OP_SHIFT: begin
					case (fmt.rView.funct)
						2'd0: nxt.ctrl.aluOp = SHL;
						2'd1: nxt.ctrl.aluOp = SHR;
						2'd2: nxt.ctrl.aluOp = INC;
						default: nxt.ctrl.aluOp = DEC;
					endcase
					if (!fmt.rView.funct[1]) nxt.ctrl.aluSrc = SRC_SHMT; // shl/shr amount
					nxt.ctrl.regLowWrite = 1'b1;
				end
				OP_LOGIC: begin
					case (fmt.rView.funct)
						2'd0: nxt.ctrl.aluOp = OR;
						2'd1: nxt.ctrl.aluOp = AND;
						2'd2: nxt.ctrl.aluOp = NOT;
						default: nxt.ctrl.aluOp = MOV;
					endcase
					nxt.ctrl.regLowWrite = 1'b1;
				end
				OP_FLAG: begin
					if (fmt.cView.op) nxt.setMask = sel;
					else nxt.clrMask = sel;
				end
				OP_CLRFLAGS: nxt.clrMask = '1; // all four
				OP_STACK: begin
					if (fmt.sView.funct == 2'd1) begin // pop
						nxt.ctrl.regLowWrite = ~fmt.sView.pc;
						nxt.clrMask.ovf = fmt.sView.pc & fmt.sView.flags; // rti
					end
				end
				OP_MEM: nxt.ctrl.regLowWrite = (fmt.rView.funct == 2'd2); // ldd
				OP_IMM: begin
					if (fmt.iView.iFunct == 3'd0) begin // ldm
						nxt.ctrl.aluSrc      = SRC_DATA;
						nxt.ctrl.regLowWrite = 1'b1;
					end
				end
				default: ; // branch, callreg need no alu controls
			endcase
		end
	end

	assign classReady = ~execValid | execReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			execValid <= 1'b0;
		end else if (classReady) begin
			execValid <= classValid;
		end
	end

	always_ff @(posedge clk) begin
		if (classValid && classReady) begin
			execOut <= nxt;
		end
	end

endmodule

//--- rtl/instrDecoder.sv
/* top of the decoder, three one-entry stages in a valid/ready chain
   one instruction in per cycle, control word out three cycles later */
`timescale 1ns/1ps

module instrDecoder (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       inValid,
	output logic                       inReady,
	input  logic [cuPkg::INSTR_W-1:0]  instr,
	output logic                       outValid,
	input  logic                       outReady,
	output cuPkg::ctrlWord_t           ctrlOut
);
	import cuPkg::*;

	logic         classValid; // stage 1 to 2
	logic         classReady;
	classInstr_t  classBus;
	logic         execValid;  // stage 2 to 3
	logic         execReady;
	execPayload_t execBus;

	decodeClassStage decodeClassStage_inst (
		.clk        (clk),
		.rst        (rst),
		.inValid    (inValid),
		.inReady    (inReady),
		.instr      (instr),
		.classValid (classValid),
		.classReady (classReady),
		.classOut   (classBus)
	);

	execCtrlStage execCtrlStage_inst (
		.clk        (clk),
		.rst        (rst),
		.classValid (classValid),
		.classReady (classReady),
		.classIn    (classBus),
		.execValid  (execValid),
		.execReady  (execReady),
		.execOut    (execBus)
	);

	memBranchCtrlStage memBranchCtrlStage_inst (
		.clk       (clk),
		.rst       (rst),
		.execValid (execValid),
		.execReady (execReady),
		.execIn    (execBus),
		.outValid  (outValid),
		.outReady  (outReady),
		.ctrlOut   (ctrlOut)
	);

endmodule

//--- rtl/memBranchCtrlStage.sv
/* decoder stage 3, adds memory, stack and jump controls
   and registers the finished control word for execute */
`timescale 1ns/1ps

module memBranchCtrlStage (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 execValid,
	output logic                 execReady,
	input  cuPkg::execPayload_t  execIn,
	output logic                 outValid,
	input  logic                 outReady,
	output cuPkg::ctrlWord_t     ctrlOut
);
	import cuPkg::*;

	instrFmt_u fmt;
	logic      immJump; // iFunct 1..5, call and jumps on immediate
	ctrlWord_t nxt;

	assign fmt     = execIn.src.fmt;
	assign immJump = (fmt.iView.iFunct != 3'd0) && (fmt.iView.iFunct <= 3'd5);

	always_comb begin
		nxt         = '0;
		nxt.exec    = execIn.ctrl;    // stage 2 results pass through
		nxt.setMask = execIn.setMask;
		nxt.clrMask = execIn.clrMask;
		nxt.spOp    = SP_HOLD;
		nxt.jmpType = JMP_ALWAYS;
		if (execIn.src.isKnown) begin
			case (execIn.src.cls)
				OP_STACK: begin
					if (fmt.sView.funct == 2'd0) begin // push
						nxt.memWrite   = 1'b1;
						nxt.spOp       = SP_PUSH;
						nxt.memDataSrc = fmt.sView.pc | fmt.sView.flags;
					end else if (fmt.sView.funct == 2'd1) begin // pop
						nxt.memRead  = 1'b1;
						nxt.spOp     = SP_POP;
						nxt.memToReg = fmt.sView.pc;
					end
					if (!fmt.sView.funct[1]) begin
						nxt.pcPushPop    = fmt.sView.pc;
						nxt.flagsPushPop = fmt.sView.flags;
						nxt.memAddrSrc   = 1'b1; // address from sp
					end
				end
				OP_MEM: begin
					nxt.memRead  = (fmt.rView.funct == 2'd2); // ldd
					nxt.memToReg = (fmt.rView.funct == 2'd2);
					nxt.memWrite = (fmt.rView.funct == 2'd3); // std
				end
				OP_CALLREG: begin
					nxt.memWrite = 1'b1; // return address onto stack
					nxt.spOp     = SP_PUSH;
					nxt.isJump   = 1'b1;
				end
				OP_BRANCH: begin
					nxt.isJump = 1'b1;
					case (fmt.rView.funct)
						2'd0: nxt.jmpType = JMP_Z;
						2'd1: nxt.jmpType = JMP_N;
						2'd2: nxt.jmpType = JMP_C;
						default: nxt.jmpType = JMP_ALWAYS;
					endcase
				end
				OP_IMM: begin
					nxt.isJump = immJump;
					nxt.jmpSrc = immJump;
					case (fmt.iView.iFunct)
						3'd1: begin // call on immediate
							nxt.memWrite = 1'b1;
							nxt.spOp     = SP_PUSH;
						end
						3'd3: nxt.jmpType = JMP_C;
						3'd4: nxt.jmpType = JMP_N;
						3'd5: nxt.jmpType = JMP_Z;
						default: ; // ldm, jmp, 6 and 7
					endcase
				end
				default: ;
			endcase
		end
	end

	assign execReady = ~outValid | outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (execReady) begin
			outValid <= execValid;
		end
	end

	always_ff @(posedge clk) begin
		if (execValid && execReady) begin
			ctrlOut <= nxt; // stable until outReady
		end
	end

endmodule

//--- testbench/instrDecoder_asserts.sv
/* concurrent checks on the decoder output link bound into instrDecoder
   the testbench reads failCount at the end of the run */
`timescale 1ns/1ps

module instrDecoder_asserts (
	input logic             clk,
	input logic             rst,
	input logic             outValid,
	input logic             outReady,
	input cuPkg::ctrlWord_t ctrlOut
);
	import cuPkg::*;

	int failCount = 0; // read at the end of the run

	resetClearsValid: assert property (@(posedge clk) rst |=> !outValid)
		else begin
			failCount++;
			$error("outValid high right after reset");
		end

	// word held while execute is stalled
	holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
		(outValid && !outReady) |=> (outValid && $stable(ctrlOut)))
		else begin
			failCount++;
			$error("control word changed while stalled");
		end

	highWriteOnlyMul: assert property (@(posedge clk) disable iff (rst)
		(outValid && ctrlOut.exec.regHighWrite) |-> (ctrlOut.exec.aluOp == MUL))
		else begin
			failCount++;
			$error("regHighWrite without MUL");
		end

	noReadAndWrite: assert property (@(posedge clk) disable iff (rst)
		outValid |-> !(ctrlOut.memRead && ctrlOut.memWrite))
		else begin
			failCount++;
			$error("memRead and memWrite both high");
		end

endmodule

bind instrDecoder instrDecoder_asserts assertsInst (
	.clk      (clk),
	.rst      (rst),
	.outValid (outValid),
	.outReady (outReady),
	.ctrlOut  (ctrlOut)
);

//--- testbench/tbInstrDecoder.sv
/* testbench for the instrDecoder pipeline with directed tests per instruction group
   and a random stream with output stalls checked against a reference decode */
`timescale 1ns/1ps

module tbInstrDecoder;
	import cuPkg::*;

	localparam int CLK_PERIOD    = 10;
	localparam int RST_CYCLES    = 10;
	localparam int PLANNED_INSTR = 255; // every instruction the tests issue

	logic               clk;
	logic               rst;
	logic               inValid;
	logic               inReady;
	logic [INSTR_W-1:0] instr;
	logic               outValid;
	logic               outReady;
	ctrlWord_t          ctrlOut;

	ctrlWord_t   expQ[$];                 // expected words in issue order
	logic [31:0] rngState   = 32'h811a;   // register fields and opcodes
	logic [31:0] stallState = 32'h811a;   // outReady pattern
	logic        stallOn    = 1'b0;
	string       testName   = "reset";
	int          errCount   = 0;
	int          checkCount = 0;
	int          testErrStart = 0;
	int          testsRun   = 0;
	int          testsFailed = 0;
	int          issued     = 0;
	int          assertFails;

	instrDecoder instrDecoder_inst (
		.clk      (clk),
		.rst      (rst),
		.inValid  (inValid),
		.inReady  (inReady),
		.instr    (instr),
		.outValid (outValid),
		.outReady (outReady),
		.ctrlOut  (ctrlOut)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// taps 32 22 2 1 with one step per bit
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			rngState = lfsrNext(rngState);
			r = {r[14:0], rngState[31]};
		end
		return r;
	endfunction

	// expected control word straight from the decode table
	function automatic ctrlWord_t refDecode(input logic [15:0] w);
		ctrlWord_t c;
		flagMask_t sel;
		logic [1:0] f;
		logic [2:0] fi;
		logic pcB;
		logic flB;
		f   = w[1:0];
		fi  = w[2:0];
		pcB = w[8];
		flB = w[7];
		sel = flagMask_t'(4'b1000 >> f); // z n c ovf
		c = '0;
		c.exec.aluOp  = MOV;
		c.exec.aluSrc = SRC_REG;
		c.spOp        = SP_HOLD;
		c.jmpType     = JMP_ALWAYS;
		case (w[15:12])
			4'd1: begin
				case (f)
					2'd0: c.exec.aluOp = DIV;
					2'd1: c.exec.aluOp = MUL;
					2'd2: c.exec.aluOp = ADD;
					default: c.exec.aluOp = SUB;
				endcase
				c.exec.regLowWrite  = 1'b1;
				c.exec.regHighWrite = (f == 2'd1);
			end
			4'd2: begin
				case (f)
					2'd0: c.exec.aluOp = SHL;
					2'd1: c.exec.aluOp = SHR;
					2'd2: c.exec.aluOp = INC;
					default: c.exec.aluOp = DEC;
				endcase
				if (f < 2'd2) c.exec.aluSrc = SRC_SHMT;
				c.exec.regLowWrite = 1'b1;
			end
			4'd3: begin
				case (f)
					2'd0: c.exec.aluOp = OR;
					2'd1: c.exec.aluOp = AND;
					2'd2: c.exec.aluOp = NOT;
					default: c.exec.aluOp = MOV;
				endcase
				c.exec.regLowWrite = 1'b1;
			end
			4'd4: begin
				c.isJump = 1'b1;
				case (f)
					2'd0: c.jmpType = JMP_Z;
					2'd1: c.jmpType = JMP_N;
					2'd2: c.jmpType = JMP_C;
					default: c.jmpType = JMP_ALWAYS;
				endcase
			end
			4'd5: begin
				if (w[11]) c.setMask = sel;
				else c.clrMask = sel;
			end
			4'd6: begin
				if (f < 2'd2) begin // push or pop
					c.pcPushPop    = pcB;
					c.flagsPushPop = flB;
					c.memAddrSrc   = 1'b1;
				end
				if (f == 2'd0) begin
					c.memWrite   = 1'b1;
					c.spOp       = SP_PUSH;
					c.memDataSrc = pcB | flB;
				end else if (f == 2'd1) begin
					c.memRead          = 1'b1;
					c.spOp             = SP_POP;
					c.memToReg         = pcB;
					c.exec.regLowWrite = ~pcB;
					c.clrMask.ovf      = pcB & flB; // return from interrupt
				end
			end
			4'd7: begin
				c.memRead          = (f == 2'd2);
				c.memToReg         = (f == 2'd2);
				c.exec.regLowWrite = (f == 2'd2);
				c.memWrite         = (f == 2'd3);
			end
			4'd8: begin
				if (fi == 3'd0) begin // ldm
					c.exec.aluSrc      = SRC_DATA;
					c.exec.regLowWrite = 1'b1;
				end
				if (fi >= 3'd1 && fi <= 3'd5) begin
					c.isJump = 1'b1;
					c.jmpSrc = 1'b1;
				end
				if (fi == 3'd1) begin
					c.memWrite = 1'b1;
					c.spOp     = SP_PUSH;
				end
				if (fi == 3'd3) c.jmpType = JMP_C;
				if (fi == 3'd4) c.jmpType = JMP_N;
				if (fi == 3'd5) c.jmpType = JMP_Z;
			end
			4'd9: c.clrMask = '1;
			4'd10: begin
				c.memWrite = 1'b1;
				c.spOp     = SP_PUSH;
				c.isJump   = 1'b1;
			end
			default: ; // nop and unused opcodes
		endcase
		return c;
	endfunction

	task automatic checkEq(input logic [63:0] expV, input logic [63:0] actV);
		checkCount++;
		if (expV !== actV) begin
			errCount++;
			$display("ERR %s expected %h actual %h", testName, expV, actV);
		end
	endtask

	// pops one expected word per output transfer
	always @(posedge clk) begin
		if (!rst && outValid && outReady) begin
			if (expQ.size() == 0) begin
				errCount++;
				$display("%s: control word %h came out with nothing pending", testName, ctrlOut);
			end else begin
				checkEq(expQ.pop_front(), ctrlOut);
			end
		end
	end

	always @(negedge clk) begin
		if (stallOn) begin
			stallState = lfsrNext(stallState);
			outReady   = stallState[31]; // about half the cycles stalled
		end else begin
			outReady = 1'b1;
		end
	end

	task automatic sendInstr(input logic [15:0] w);
		@(negedge clk);
		instr   = w;
		inValid = 1'b1;
		expQ.push_back(refDecode(w));
		issued++;
		do @(posedge clk); while (!inReady); // hold until accepted
	endtask

	task automatic drain();
		int n;
		@(negedge clk);
		inValid = 1'b0;
		n = 0;
		while (expQ.size() != 0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (expQ.size() != 0) begin
			errCount++;
			$display("%s: %0d control words never came out", testName, expQ.size());
			expQ.delete();
		end
	endtask

	task automatic startTest(input string name);
		testName     = name;
		testErrStart = errCount;
	endtask

	task automatic finishTest();
		drain();
		testsRun++;
		if (errCount != testErrStart) testsFailed++;
		$display("%-10s %s, %0d errors", testName,
			(errCount == testErrStart) ? "ok" : "FAILED", errCount - testErrStart);
	endtask

	task automatic aluOps();
		logic [15:0] r;
		startTest("alu");
		for (int op = 1; op <= 3; op++) begin
			for (int f = 0; f < 4; f++) begin
				r = randBits(10);
				sendInstr({op[3:0], r[9:0], f[1:0]});
			end
		end
		finishTest();
	endtask

	task automatic flagMasks();
		logic [15:0] r;
		startTest("flags");
		for (int s = 0; s < 2; s++) begin
			for (int f = 0; f < 4; f++) begin
				r = randBits(9);
				sendInstr({4'd5, s[0], r[8:0], f[1:0]});
			end
		end
		r = randBits(12);
		sendInstr({4'd9, r[11:0]});
		r = randBits(8);
		sendInstr({4'd6, r[7:5], 2'b11, r[4:0], 2'd1}); // rti
		finishTest();
	endtask

	task automatic stackAndMemory();
		logic [15:0] r;
		startTest("stackMem");
		for (int f = 0; f < 2; f++) begin
			for (int pf = 0; pf < 4; pf++) begin
				r = randBits(8);
				sendInstr({4'd6, r[7:5], pf[1:0], r[4:0], f[1:0]});
			end
		end
		r = randBits(10);
		sendInstr({4'd7, r[9:0], 2'd2}); // ldd
		sendInstr({4'd7, r[9:0], 2'd3}); // std
		r = randBits(12);
		sendInstr({4'd10, r[11:0]});
		r = randBits(9);
		sendInstr({4'd8, r[8:0], 3'd1}); // call on immediate
		finishTest();
	endtask

	task automatic jumpControls();
		logic [15:0] r;
		startTest("jumps");
		for (int f = 0; f < 4; f++) begin
			r = randBits(10);
			sendInstr({4'd4, r[9:0], f[1:0]});
		end
		for (int fi = 0; fi < 8; fi++) begin
			r = randBits(9);
			sendInstr({4'd8, r[8:0], fi[2:0]}); // ldm, jumps, 6 and 7
		end
		finishTest();
	endtask

	task automatic inactiveCodes();
		logic [15:0] r;
		startTest("inactive");
		r = randBits(12);
		sendInstr({4'd0, r[11:0]});
		for (int op = 11; op < 16; op++) begin
			r = randBits(12);
			sendInstr({op[3:0], r[11:0]});
		end
		r = randBits(10);
		sendInstr({4'd7, r[9:0], 2'd0}); // out
		sendInstr({4'd7, r[9:0], 2'd1}); // in
		finishTest();
	endtask

	task automatic stalledStream();
		logic [15:0] r;
		int lat;
		startTest("stream");
		stallOn = 1'b1;
		repeat (200) begin
			r = randBits(16);
			sendInstr(r);
		end
		stallOn = 1'b0;
		drain();
		@(negedge clk); // pipeline empty and outReady high from here
		checkEq(1, inReady);
		r       = randBits(16);
		instr   = r;
		inValid = 1'b1;
		expQ.push_back(refDecode(r));
		issued++;
		lat = 0;
		do begin
			@(negedge clk);
			inValid = 1'b0;
			lat++;
		end while (!outValid && lat < 8);
		checkEq(3, lat); // cycles from accept to outValid
		finishTest();
	endtask

	initial begin
		#(CLK_PERIOD * (RST_CYCLES + 40 * PLANNED_INSTR));
		$display("watchdog expired during %s, the decoder stopped moving", testName);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst      = 1'b1;
		inValid  = 1'b0;
		instr    = '0;
		outReady = 1'b1;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		aluOps();
		flagMasks();
		stackAndMemory();
		jumpControls();
		inactiveCodes();
		stalledStream();
		assertFails = instrDecoder_inst.assertsInst.failCount;
		if (assertFails != 0) $display("%0d assertion failures on the output link", assertFails);
		errCount += assertFails;
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d issued",
			testsRun, testsFailed, checkCount, errCount, issued);
		if (errCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
